/* list.f */
logic/ctr_pkg.sv
logic/ctr_req_check.sv
logic/ctr_slice_fsm.sv
logic/ctr_state_reg.sv
logic/ctr_unit.sv
tb/tb_ctr_unit.sv

/* Makefile */
# Verilator build and run of the counter unit testbench

TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_ctr_unit
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_ctr_unit.sv */
//////////////////////////////////////////////////
// Counter unit testbench
// Random loads and increments against a model,
// then rail faults with a reset in between
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_ctr_unit;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic                          incr_i;
  logic                          incr_ni;
  logic                          load_i;
  logic                          load_ni;
  logic [ctr_pkg::CtrWidth-1:0]  load_data_i;
  logic                          ready_o;
  logic                          alert_o;
  logic [ctr_pkg::CtrWidth-1:0]  ctr_o;

  // Model of the counter and random source
  logic [ctr_pkg::CtrWidth-1:0]  model;
  logic [31:0]                   lfsr_state = 32'hbc15_4737;

  ctr_unit uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .incr_i      (incr_i),
    .incr_ni     (incr_ni),
    .load_i      (load_i),
    .load_ni     (load_ni),
    .load_data_i (load_data_i),
    .ready_o     (ready_o),
    .alert_o     (alert_o),
    .ctr_o       (ctr_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    int unsigned i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Slices mostly all ones, for long carry chains
  function automatic logic [ctr_pkg::CtrWidth-1:0] rand_word();
    logic [ctr_pkg::CtrWidth-1:0] w;
    logic [31:0] r;
    int unsigned s;
    for (s = 0; s < ctr_pkg::NumSlicesCtr; s++) begin
      r = rand_bits(2);
      if (r[1:0] != 2'b00) begin
        w[s*ctr_pkg::SliceSizeCtr +: ctr_pkg::SliceSizeCtr] = '1;
      end else begin
        r = rand_bits(ctr_pkg::SliceSizeCtr);
        w[s*ctr_pkg::SliceSizeCtr +: ctr_pkg::SliceSizeCtr] = r[ctr_pkg::SliceSizeCtr-1:0];
      end
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Checks and drivers
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [ctr_pkg::CtrWidth-1:0] got,
                           input logic [ctr_pkg::CtrWidth-1:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_timeout(input int unsigned waited, input string what);
    assert (waited < 64) else begin
      $display("Timeout while waiting for %s", what);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // Clean rails, no request
  task automatic drive_idle();
    incr_i      <= 1'b0;
    incr_ni     <= 1'b1;
    load_i      <= 1'b0;
    load_ni     <= 1'b1;
    load_data_i <= rand_word();
  endtask

  // Random requests on clean rails
  task automatic drive_noise();
    logic [31:0] r;
    r = rand_bits(2);
    incr_i      <= r[0];
    incr_ni     <= ~r[0];
    load_i      <= r[1];
    load_ni     <= ~r[1];
    load_data_i <= rand_word();
  endtask

  // Returns at a falling edge with ready_o high
  task automatic wait_ready();
    int unsigned waited;
    waited = 0;
    while (!ready_o) begin
      waited++;
      check_timeout(waited, "ready_o");
      @(negedge clk_i);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    drive_idle();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    model = '0;
    check_val("ready_o", ctr_pkg::CtrWidth'(ready_o), ctr_pkg::CtrWidth'(1));
    check_val("alert_o", ctr_pkg::CtrWidth'(alert_o), '0);
    check_val("ctr_o", ctr_o, model);
  endtask

  // One accepted request, busy phase filled with dropped strobes
  task automatic run_request(input logic do_load, input logic do_incr,
                             input logic [ctr_pkg::CtrWidth-1:0] data);
    int unsigned low_cycles;
    low_cycles = 0;
    wait_ready();
    @(posedge clk_i);
    incr_i      <= do_incr;
    incr_ni     <= ~do_incr;
    load_i      <= do_load;
    load_ni     <= ~do_load;
    load_data_i <= data;
    // Request accepted at this edge
    @(posedge clk_i);
    drive_idle();
    if (do_load) begin
      model = data;
    end
    if (do_incr) begin
      model = model + 128'd1;
    end
    @(negedge clk_i);
    while (!ready_o) begin
      low_cycles++;
      check_timeout(low_cycles, "end of increment");
      @(posedge clk_i);
      // Strobes sampled only while busy
      if (low_cycles < ctr_pkg::NumSlicesCtr) begin
        drive_noise();
      end else begin
        drive_idle();
      end
      @(negedge clk_i);
    end
    check_val("ready_o low cycles", ctr_pkg::CtrWidth'(low_cycles),
              ctr_pkg::CtrWidth'(do_incr ? ctr_pkg::NumSlicesCtr : 0));
    check_val("alert_o", ctr_pkg::CtrWidth'(alert_o), '0);
    check_val("ctr_o", ctr_o, model);
  endtask

  // Equal rails on one request pair, then requests under alert
  task automatic inject_rail_fault(input logic on_incr);
    logic [31:0] r;
    int unsigned stretch;
    int unsigned i;
    wait_ready();
    r = rand_bits(1);
    @(posedge clk_i);
    if (on_incr) begin
      incr_i  <= r[0];
      incr_ni <= r[0];
    end else begin
      load_i  <= r[0];
      load_ni <= r[0];
    end
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_val("alert_o", ctr_pkg::CtrWidth'(alert_o), ctr_pkg::CtrWidth'(1));
    r = rand_bits(6);
    stretch = 64 + r;
    for (i = 0; i < stretch; i++) begin
      @(posedge clk_i);
      drive_noise();
      @(negedge clk_i);
      check_val("alert_o", ctr_pkg::CtrWidth'(alert_o), ctr_pkg::CtrWidth'(1));
      check_val("ready_o", ctr_pkg::CtrWidth'(ready_o), '0);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] op;
    int unsigned n;
    rst_ni      = 1'b0;
    incr_i      = 1'b0;
    incr_ni     = 1'b1;
    load_i      = 1'b0;
    load_ni     = 1'b1;
    load_data_i = '0;
    model       = '0;
    apply_reset();

    // Wrap to zero, separate and in the same cycle
    run_request(1'b1, 1'b0, '1);
    run_request(1'b0, 1'b1, '0);
    run_request(1'b1, 1'b1, '1);

    for (n = 0; n < 40; n++) begin
      op = rand_bits(2);
      case (op[1:0])
        2'b00: run_request(1'b1, 1'b1, rand_word());
        2'b01: run_request(1'b0, 1'b1, '0);
        default: begin
          run_request(1'b1, 1'b0, rand_word());
          run_request(1'b0, 1'b1, '0);
        end
      endcase
    end
    inject_rail_fault(1'b1);

    // Second phase ends in a load rail fault
    apply_reset();
    for (n = 0; n < 10; n++) begin
      run_request(1'b1, 1'b1, rand_word());
    end
    inject_rail_fault(1'b0);

    $display("Everything OK");
    $finish;
  end

endmodule

/* logic/ctr_unit.sv */
//////////////////////////////////////////////////
// Counter unit top level
// Request checker, slice FSM and counter storage
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ctr_unit (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Requests on complementary rails
  input  logic                             incr_i,
  input  logic                             incr_ni,
  input  logic                             load_i,
  input  logic                             load_ni,
  input  logic [ctr_pkg::CtrWidth-1:0]     load_data_i,

  // Status and counter
  output logic                             ready_o,
  output logic                             alert_o,
  output logic [ctr_pkg::CtrWidth-1:0]     ctr_o
);

  // Qualified requests and rail errors
  logic incr;
  logic load;
  logic incr_err;
  logic mr_err;

  // FSM to storage
  logic                                  ctr_we;
  logic [ctr_pkg::SliceIdxWidth-1:0]     ctr_slice_idx;
  logic [ctr_pkg::SliceSizeCtr-1:0]      slice_rd;
  logic [ctr_pkg::SliceSizeCtr-1:0]      slice_wr;

  ctr_req_check u_req_check (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .incr_i     (incr_i),
    .incr_ni    (incr_ni),
    .load_i     (load_i),
    .load_ni    (load_ni),
    .incr_o     (incr),
    .load_o     (load),
    .incr_err_o (incr_err),
    .mr_err_o   (mr_err)
  );

  ctr_slice_fsm u_slice_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .incr_i          (incr),
    .ready_o         (ready_o),
    .incr_err_i      (incr_err),
    .mr_err_i        (mr_err),
    .alert_o         (alert_o),
    .ctr_slice_idx_o (ctr_slice_idx),
    .ctr_slice_i     (slice_rd),
    .ctr_slice_o     (slice_wr),
    .ctr_we_o        (ctr_we)
  );

  ctr_state_reg u_state_reg (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .load_i          (load),
    .ready_i         (ready_o),
    .load_data_i     (load_data_i),
    .alert_i         (alert_o),
    .ctr_we_i        (ctr_we),
    .ctr_slice_idx_i (ctr_slice_idx),
    .ctr_slice_i     (slice_wr),
    .ctr_slice_o     (slice_rd),
    .ctr_o           (ctr_o)
  );

endmodule

/* logic/ctr_state_reg.sv */
//////////////////////////////////////////////////
// Counter storage
// Holds the counter as slice registers with
// whole-word load, slice read and slice write
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ctr_state_reg (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Whole-word load, gated by ready
  input  logic                                 load_i,
  input  logic                                 ready_i,
  input  logic [ctr_pkg::CtrWidth-1:0]         load_data_i,

  // Freeze after an error
  input  logic                                 alert_i,

  // Slice access from the FSM
  input  logic                                 ctr_we_i,
  input  logic [ctr_pkg::SliceIdxWidth-1:0]    ctr_slice_idx_i,
  input  logic [ctr_pkg::SliceSizeCtr-1:0]     ctr_slice_i,
  output logic [ctr_pkg::SliceSizeCtr-1:0]     ctr_slice_o,

  // Full counter value
  output logic [ctr_pkg::CtrWidth-1:0]         ctr_o
);

  // Counter as packed slices, slice 0 least significant
  logic [ctr_pkg::NumSlicesCtr-1:0][ctr_pkg::SliceSizeCtr-1:0] ctr_q;

  // Qualified write enables
  logic load_en;
  logic slice_en;

  //////////////////////////////////////////////////
  // Write control
  //////////////////////////////////////////////////

  // No writes at all once alerted
  assign load_en  = load_i & ready_i & ~alert_i;
  assign slice_en = ctr_we_i & ~alert_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else if (load_en) begin
      ctr_q <= load_data_i;
    end else if (slice_en) begin
      ctr_q[ctr_slice_idx_i] <= ctr_slice_i;
    end
  end

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  // Addressed slice back to the FSM
  assign ctr_slice_o = ctr_q[ctr_slice_idx_i];

  // Whole word out
  assign ctr_o = ctr_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Ready from the FSM keeps loads and slice writes apart
  load_vs_write_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (load_i && ready_i) |-> !ctr_we_i
  );

endmodule

/* logic/ctr_slice_fsm.sv */
//////////////////////////////////////////////////
// Counter slice FSM
// Adds one to the counter a slice per cycle,
// carry passed upward, with a terminal error state
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ctr_slice_fsm (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Request side
  input  logic                                 incr_i,
  output logic                                 ready_o,
  input  logic                                 incr_err_i,
  input  logic                                 mr_err_i,
  output logic                                 alert_o,

  // Counter storage side
  output logic [ctr_pkg::SliceIdxWidth-1:0]    ctr_slice_idx_o,
  input  logic [ctr_pkg::SliceSizeCtr-1:0]     ctr_slice_i,
  output logic [ctr_pkg::SliceSizeCtr-1:0]     ctr_slice_o,
  output logic                                 ctr_we_o
);

  // State and slice walk
  ctr_pkg::ctr_state_e                   state_d, state_q;
  logic [ctr_pkg::SliceIdxWidth-1:0]     slice_idx_d, slice_idx_q;
  logic                                  carry_d, carry_q;

  // Slice sum with carry out on top
  logic [ctr_pkg::SliceSizeCtr:0]        slice_sum;

  //////////////////////////////////////////////////
  // Slice adder
  //////////////////////////////////////////////////

  assign slice_sum   = {1'b0, ctr_slice_i} +
                       {{ctr_pkg::SliceSizeCtr{1'b0}}, carry_q};
  assign ctr_slice_o = slice_sum[ctr_pkg::SliceSizeCtr-1:0];

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_comb begin
    // Output defaults
    ready_o  = 1'b0;
    ctr_we_o = 1'b0;
    alert_o  = 1'b0;

    // Hold by default
    state_d     = state_q;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;

    case (state_q)
      ctr_pkg::CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at the least significant slice, adding one
          slice_idx_d = '0;
          carry_d     = 1'b1;
          state_d     = ctr_pkg::CTR_INCR;
        end
      end

      ctr_pkg::CTR_INCR: begin
        // Write back the sum and step to the next slice
        ctr_we_o    = 1'b1;
        slice_idx_d = slice_idx_q + ctr_pkg::SliceIdxWidth'(1);
        carry_d     = slice_sum[ctr_pkg::SliceSizeCtr];
        if (slice_idx_q == ctr_pkg::SliceIdxWidth'(ctr_pkg::NumSlicesCtr - 1)) begin
          state_d = ctr_pkg::CTR_IDLE;
        end
      end

      ctr_pkg::CTR_ERROR: begin
        // Terminal, left only through reset
        alert_o = 1'b1;
      end

      default: begin
        // Corrupted state code
        alert_o = 1'b1;
        state_d = ctr_pkg::CTR_ERROR;
      end
    endcase

    // Rail faults override everything
    if (incr_err_i || mr_err_i) begin
      state_d = ctr_pkg::CTR_ERROR;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ctr_pkg::CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  // Current slice address to storage
  assign ctr_slice_idx_o = slice_idx_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Only the two working states outside an alert
  state_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !alert_o |-> state_q inside {ctr_pkg::CTR_IDLE, ctr_pkg::CTR_INCR}
  );

  // Busy writing means not ready
  we_not_ready_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(ctr_we_o && ready_o)
  );

endmodule

/* logic/ctr_req_check.sv */
//////////////////////////////////////////////////
// Counter request checker
// Qualifies each request strobe by its inverted
// rail and flags rails that agree in value
//////////////////////////////////////////////////

`timescale 1ns/1ns

module ctr_req_check (
  input  logic clk_i,
  input  logic rst_ni,

  // Increment request, true and inverted rail
  input  logic incr_i,
  input  logic incr_ni,

  // Load request, true and inverted rail
  input  logic load_i,
  input  logic load_ni,

  // Qualified strobes
  output logic incr_o,
  output logic load_o,

  // Rail errors
  output logic incr_err_o,
  output logic mr_err_o
);

  //////////////////////////////////////////////////
  // Rail comparison
  //////////////////////////////////////////////////

  // Equal rails point to a glitch or a fault
  assign incr_err_o = (incr_i == incr_ni);
  assign mr_err_o   = (load_i == load_ni);

  // Strobes only pass on clean rails
  assign incr_o = incr_i & ~incr_err_o;
  assign load_o = load_i & ~mr_err_o;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Qualified increment never together with its error
  incr_no_err_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    incr_err_o |-> !incr_o
  );

  // Qualified load never together with its error
  load_no_err_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mr_err_o |-> !load_o
  );

endmodule

/* logic/ctr_pkg.sv */
//////////////////////////////////////////////////
// Counter unit package
// Counter geometry and the FSM state type shared
// by the counter mode blocks
//////////////////////////////////////////////////

package ctr_pkg;

  //////////////////////////////////////////////////
  // Counter geometry
  //////////////////////////////////////////////////

  // Full counter word
  localparam int unsigned CtrWidth = 128;

  // One slice handled per clock cycle
  localparam int unsigned SliceSizeCtr = 16;

  // Slices per counter word
  localparam int unsigned NumSlicesCtr = CtrWidth / SliceSizeCtr;

  // Slice index width
  localparam int unsigned SliceIdxWidth = $clog2(NumSlicesCtr);

  //////////////////////////////////////////////////
  // FSM state
  //////////////////////////////////////////////////

  // Encodings at least two bit flips apart,
  // so a single upset lands in the default branch
  typedef enum logic [2:0] {
    CTR_IDLE  = 3'b011,
    CTR_INCR  = 3'b101,
    CTR_ERROR = 3'b110
  } ctr_state_e;

endpackage
